/* project.f */
refill_pkg.sv
refill_receiver.sv
refill_data_downsize.sv
refill_word_writer.sv
refill_downsize_top.sv
refill_downsize_assertions.sv
refill_downsize_tb.sv

/* refill_downsize_tb.sv */
// Refill data path testbench with memory driver, array responder and word scoreboard
`timescale 1ns/1ns

module refill_downsize_tb
    import refill_pkg::*;
();

    // Beats over all tests, used for the run limit
    localparam int TOTAL_BEATS     = 1 + 5 + 3 + 64;
    localparam int CYCLES_PER_WORD = 12;
    localparam int TIMEOUT_CYCLES  = TOTAL_BEATS * RD_WORDS * CYCLES_PER_WORD + 500;

    // Array side quiet this long means no further word is coming
    localparam int DRAIN_IDLE_CYCLES = 16;

    logic         clk;
    logic         rst_n;
    logic         mem_req;
    refill_data_t mem_data;
    logic         mem_ack;
    logic         arr_req;
    word_data_t   arr_data;
    word_idx_t    arr_idx;
    logic         arr_ack;

    // Expected words and offsets in arrival order
    word_data_t exp_data_q[$];
    word_idx_t  exp_idx_q[$];

    string test_name   = "reset";
    int    rx_count    = 0;
    int    beats_sent  = 0;
    int    max_mem_wait = 0;
    int    cycle_count = 0;
    logic  slow_ack    = 1'b0;
    logic  req_prev    = 1'b0;

    refill_downsize_top refill_downsize_top_inst (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .mem_req_i  (mem_req),
        .mem_data_i (mem_data),
        .mem_ack_o  (mem_ack),
        .arr_req_o  (arr_req),
        .arr_data_o (arr_data),
        .arr_idx_o  (arr_idx),
        .arr_ack_i  (arr_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Word at a position counted from the LSB end of the beat
    function automatic word_data_t ref_word(input refill_data_t beat, input int pos);
        return beat[pos*WORD_WIDTH +: WORD_WIDTH];
    endfunction

    // Array side latency, fixed and long while back-pressure is wanted
    function automatic int pick_ack_delay();
        if (slow_ack) begin
            return 5;
        end
        return $urandom_range(5, 0);
    endfunction

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [REFILL_WIDTH-1:0] expected,
                               input logic [REFILL_WIDTH-1:0] actual);
        if (expected !== actual) begin
            $display("mismatch test=%s check=%s expected=%0h actual=%0h",
                     test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    // Four-phase master on the memory side, called on a falling edge
    task automatic send_beat(input refill_data_t beat);
        int waited;
        for (int i = 0; i < RD_WORDS; i++) begin
            exp_data_q.push_back(ref_word(beat, i));
            exp_idx_q.push_back(word_idx_t'(i));
        end
        mem_data = beat;
        mem_req  = 1'b1;
        waited   = 0;
        while (!mem_ack) begin
            @(negedge clk);
            waited++;
        end
        if (waited > max_mem_wait) begin
            max_mem_wait = waited;
        end
        mem_req = 1'b0;
        while (mem_ack) begin
            @(negedge clk);
        end
        beats_sent++;
    endtask

    // Wait for the expected words, or stop waiting once the array side stalls
    task automatic drain_words();
        int idle_cycles;
        idle_cycles = 0;
        while ((exp_data_q.size() != 0 && idle_cycles < DRAIN_IDLE_CYCLES) || arr_req) begin
            @(negedge clk);
            if (arr_req) begin
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
        end
    endtask

    // Array side responder
    initial begin
        int delay;
        arr_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (arr_req && !arr_ack) begin
                delay = pick_ack_delay();
                repeat (delay) @(negedge clk);
                arr_ack = 1'b1;
                while (arr_req) begin
                    @(negedge clk);
                end
                delay = pick_ack_delay();
                repeat (delay) @(negedge clk);
                arr_ack = 1'b0;
            end
        end
    end

    // Compare on each new request, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            req_prev = 1'b0;
        end else begin
            if (arr_req && !req_prev) begin
                if (exp_data_q.size() == 0) begin
                    $display("array side got a word while no beat was outstanding");
                    stop_with_failure();
                end else begin
                    check_value("data", exp_data_q.pop_front(), arr_data);
                    check_value("index", exp_idx_q.pop_front(), arr_idx);
                    rx_count++;
                end
            end
            req_prev = arr_req;
        end
    end

    // Run limit
    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles in test %s", cycle_count, test_name);
                stop_with_failure();
            end
        end
    end

    initial begin
        int base_count;
        refill_data_t beat;
        void'($urandom(49));
        mem_req  = 1'b0;
        mem_data = '0;
        rst_n    = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // One beat, four words lowest first
        test_name  = "single beat";
        base_count = rx_count;
        send_beat(64'h4444_3333_2222_1111);
        drain_words();
        check_value("word count", RD_WORDS, rx_count - base_count);

        // Slow array side fills the buffer
        test_name    = "back-pressure";
        slow_ack     = 1'b1;
        max_mem_wait = 0;
        base_count   = rx_count;
        for (int b = 0; b < 5; b++) begin
            send_beat({4{16'(16'hb000 + b)}} ^ 64'h0003_0002_0001_0000);
        end
        drain_words();
        slow_ack = 1'b0;
        check_value("word count", 5 * RD_WORDS, rx_count - base_count);
        check_value("mem ack delayed", 1, max_mem_wait > 2);

        // Offsets wrap from one beat into the next
        test_name  = "index wrap";
        base_count = rx_count;
        for (int b = 0; b < 3; b++) begin
            send_beat(64'h0003_0002_0001_0000 + {4{16'(b << 8)}});
        end
        drain_words();
        check_value("word count", 3 * RD_WORDS, rx_count - base_count);

        // Random beats with random gaps
        test_name  = "random traffic";
        base_count = rx_count;
        for (int b = 0; b < 64; b++) begin
            beat = {$urandom(), $urandom()};
            send_beat(beat);
            repeat ($urandom_range(4, 0)) @(negedge clk);
        end
        drain_words();
        check_value("word count", 64 * RD_WORDS, rx_count - base_count);

        // Nothing left over and nothing lost
        test_name = "completion";
        check_value("scoreboard size", 0, exp_data_q.size());
        check_value("word total", beats_sent * RD_WORDS, rx_count);

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* refill_downsize_assertions.sv */
// Refill data path protocol checker for the memory and array handshakes
`timescale 1ns/1ns

module refill_downsize_assertions
    import refill_pkg::*;
(
    input logic       clk_i,
    input logic       rst_ni,
    input logic       mem_req_i,
    input logic       mem_ack_o,
    input logic       arr_req_o,
    input word_data_t arr_data_o,
    input word_idx_t  arr_idx_o,
    input logic       arr_ack_i
);

    // Req held until the array acknowledges
    property arr_req_held_p;
        @(posedge clk_i) disable iff (!rst_ni)
        (arr_req_o && !arr_ack_i) |=> arr_req_o;
    endproperty

    // Payload frozen during the request phase
    property arr_payload_stable_p;
        @(posedge clk_i) disable iff (!rst_ni)
        (arr_req_o && !arr_ack_i) |=> ($stable(arr_data_o) && $stable(arr_idx_o));
    endproperty

    // Ack only answers a pending request
    property mem_ack_needs_req_p;
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(mem_ack_o) |-> $past(mem_req_i);
    endproperty

    // Both handshake outputs cleared by reset
    property reset_outputs_low_p;
        @(posedge clk_i)
        !rst_ni |=> (!mem_ack_o && !arr_req_o);
    endproperty

    arr_req_held_a: assert property (arr_req_held_p)
        else $error("arr_req_o dropped before arr_ack_i was seen");

    arr_payload_stable_a: assert property (arr_payload_stable_p)
        else $error("arr_data_o or arr_idx_o changed during the request phase");

    mem_ack_needs_req_a: assert property (mem_ack_needs_req_p)
        else $error("mem_ack_o rose without mem_req_i high");

    reset_outputs_low_a: assert property (reset_outputs_low_p)
        else $error("handshake outputs not low during reset");

endmodule

bind refill_downsize_top refill_downsize_assertions refill_downsize_assertions_inst (.*);

/* refill_downsize_top.sv */
// Refill data path top: memory-side receiver, downsizing FIFO and array-side word writer
`timescale 1ns/1ns

module refill_downsize_top
    import refill_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    // Memory side
    input  logic         mem_req_i,
    input  refill_data_t mem_data_i,
    output logic         mem_ack_o,

    // Data array side
    output logic         arr_req_o,
    output word_data_t   arr_data_o,
    output word_idx_t    arr_idx_o,
    input  logic         arr_ack_i
);

    // Receiver to buffer
    logic         push;
    refill_data_t push_data;
    logic         push_ok;

    // Buffer to writer
    logic         pop;
    logic         pop_ok;
    word_data_t   pop_data;

    refill_receiver refill_receiver_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mem_req_i   (mem_req_i),
        .mem_data_i  (mem_data_i),
        .mem_ack_o   (mem_ack_o),
        .push_o      (push),
        .push_data_o (push_data),
        .push_ok_i   (push_ok)
    );

    refill_data_downsize refill_data_downsize_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_data_i (push_data),
        .push_ok_o   (push_ok),
        .pop_i       (pop),
        .pop_ok_o    (pop_ok),
        .pop_data_o  (pop_data)
    );

    refill_word_writer refill_word_writer_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .pop_o      (pop),
        .pop_ok_i   (pop_ok),
        .pop_data_i (pop_data),
        .arr_req_o  (arr_req_o),
        .arr_data_o (arr_data_o),
        .arr_idx_o  (arr_idx_o),
        .arr_ack_i  (arr_ack_i)
    );

endmodule

/* refill_word_writer.sv */
// Word writer: pops narrow words and issues each with its offset as a four-phase master
`timescale 1ns/1ns

module refill_word_writer
    import refill_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // From the downsizing buffer
    output logic       pop_o,
    input  logic       pop_ok_i,
    input  word_data_t pop_data_i,

    // Toward the cache data array, four-phase req/ack
    output logic       arr_req_o,
    output word_data_t arr_data_o,
    output word_idx_t  arr_idx_o,
    input  logic       arr_ack_i
);

    // FSM as two flags, both low means idle
    logic req_q;
    logic rel_q;

    // Word offset of the next word to pop
    word_idx_t idx_q;

    // Latched payload toward the array
    word_data_t arr_data_q;
    word_idx_t  arr_idx_q;

    logic pop_fire;

    // Pop only from idle
    assign pop_o    = !req_q && !rel_q;
    assign pop_fire = pop_o && pop_ok_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            rel_q <= 1'b0;
            idx_q <= '0;
        end else begin
            if (pop_fire) begin
                req_q <= 1'b1;
                // Offset wraps at the end of each beat
                if (idx_q == word_idx_t'(RD_WORDS-1)) begin
                    idx_q <= '0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
            // Ack seen, drop req and wait for release
            if (req_q && arr_ack_i) begin
                req_q <= 1'b0;
                rel_q <= 1'b1;
            end
            // Ack low again closes the transfer
            if (rel_q && !arr_ack_i) begin
                rel_q <= 1'b0;
            end
        end
    end

    // Held stable until the next pop
    always_ff @(posedge clk_i) begin
        if (pop_fire) begin
            arr_data_q <= pop_data_i;
            arr_idx_q  <= idx_q;
        end
    end

    assign arr_req_o  = req_q;
    assign arr_data_o = arr_data_q;
    assign arr_idx_o  = arr_idx_q;

endmodule

/* refill_data_downsize.sv */
// Downsizing FIFO: stores whole refill beats and hands them out one narrow word at a time
`timescale 1ns/1ns

module refill_data_downsize
    import refill_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    // Write side, one full beat per push
    input  logic         push_i,
    input  refill_data_t push_data_i,
    output logic         push_ok_o,

    // Read side, one narrow word per pop
    input  logic         pop_i,
    output logic         pop_ok_o,
    output word_data_t   pop_data_o
);

    // Beat storage, viewed as words so the read side can index it
    word_data_t [BUF_DEPTH-1:0][RD_WORDS-1:0] buf_q;

    // Slot pointers
    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] wr_ptr_d;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_d;

    // Occupied slots, one extra bit to tell full from empty
    logic [PTR_WIDTH:0] used_q;
    logic [PTR_WIDTH:0] used_d;

    // Remaining words after the current one, per slot
    word_idx_t [BUF_DEPTH-1:0] words_q;
    word_idx_t [BUF_DEPTH-1:0] words_d;

    // Handshake fires and slot release
    logic push_fire;
    logic pop_fire;
    logic slot_done;

    // Word position shown from the read slot
    word_idx_t rd_word;

    assign push_ok_o = (used_q != (PTR_WIDTH+1)'(BUF_DEPTH));
    assign pop_ok_o  = (used_q != '0);

    assign push_fire = push_i && push_ok_o;
    assign pop_fire  = pop_i && pop_ok_o;

    // Last word of the slot is being read out
    assign slot_done = pop_fire && (words_q[rd_ptr_q] == '0);

    always_comb begin
        wr_ptr_d = wr_ptr_q;
        rd_ptr_d = rd_ptr_q;
        used_d   = used_q;
        words_d  = words_q;

        // Circular advance of the write pointer
        if (push_fire) begin
            if (wr_ptr_q == PTR_WIDTH'(BUF_DEPTH-1)) begin
                wr_ptr_d = '0;
            end else begin
                wr_ptr_d = wr_ptr_q + 1'b1;
            end
            words_d[wr_ptr_q] = word_idx_t'(RD_WORDS-1);
        end

        if (pop_fire && !slot_done) begin
            words_d[rd_ptr_q] = words_q[rd_ptr_q] - 1'b1;
        end

        // Release the slot, move on to the next beat
        if (slot_done) begin
            if (rd_ptr_q == PTR_WIDTH'(BUF_DEPTH-1)) begin
                rd_ptr_d = '0;
            end else begin
                rd_ptr_d = rd_ptr_q + 1'b1;
            end
        end

        // Push and release together leave the count unchanged
        case ({push_fire, slot_done})
            2'b10:   used_d = used_q + 1'b1;
            2'b01:   used_d = used_q - 1'b1;
            default: used_d = used_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            used_q   <= '0;
            words_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_d;
            rd_ptr_q <= rd_ptr_d;
            used_q   <= used_d;
            words_q  <= words_d;
        end
    end

    // Storage written whole on push
    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            buf_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Count runs down, so the lowest word comes out first
    assign rd_word    = word_idx_t'(RD_WORDS-1) - words_q[rd_ptr_q];
    assign pop_data_o = buf_q[rd_ptr_q][rd_word];

endmodule

/* refill_receiver.sv */
// Refill receiver: four-phase slave on the memory side that pushes each beat into the buffer
`timescale 1ns/1ns

module refill_receiver
    import refill_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    // Memory side, four-phase req/ack
    input  logic         mem_req_i,
    input  refill_data_t mem_data_i,
    output logic         mem_ack_o,

    // Toward the downsizing buffer
    output logic         push_o,
    output refill_data_t push_data_o,
    input  logic         push_ok_i
);

    // Handshake state, low is idle and high is acknowledged
    logic ack_q;

    // Beat accepted on this edge
    logic accept;

    // Only offer a push while idle with a pending request
    assign push_o = !ack_q && mem_req_i;

    // Data is stable while req is high, so push it straight through
    assign push_data_o = mem_data_i;

    // Buffer full keeps us idle, ack is delayed as long as needed
    assign accept = push_o && push_ok_i;

    // Ack follows the state register, one cycle after the accepting edge
    assign mem_ack_o = ack_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q <= 1'b0;
        end else begin
            if (accept) begin
                // Beat captured by the buffer, raise ack
                ack_q <= 1'b1;
            end else if (ack_q && !mem_req_i) begin
                // Req released, drop ack and rearm
                ack_q <= 1'b0;
            end
        end
    end

    // A second push for the same beat is impossible
    // since req must fall before we leave the acknowledged state

endmodule

/* refill_pkg.sv */
// Refill data path package with beat and word widths, buffer depth and shared types
package refill_pkg;

    // Wide refill beat delivered by the memory side
    localparam int REFILL_WIDTH = 64;

    // Narrow word written into the cache data array
    localparam int WORD_WIDTH = 16;

    // Narrow words carried by one beat
    localparam int RD_WORDS = REFILL_WIDTH / WORD_WIDTH;

    // Beats held by the downsizing buffer
    localparam int BUF_DEPTH = 2;

    // Bits to count the words of a beat
    localparam int WORD_IDX_WIDTH = $clog2(RD_WORDS);

    // Bits of a buffer slot pointer
    localparam int PTR_WIDTH = $clog2(BUF_DEPTH);

    // One full refill beat
    typedef logic [REFILL_WIDTH-1:0] refill_data_t;

    // One narrow word toward the array
    typedef logic [WORD_WIDTH-1:0] word_data_t;

    // Word offset inside a beat, also used as remaining-word count
    typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;

endpackage
